//--- Makefile
VERILATOR  ?= verilator
FILELIST   := tb.f
TB_TOP     := commit_tb
RTL_TOP    := commit_stage
LINT_FLAGS := --lint-only --timing -sv
SIM_FLAGS  := --binary --timing --assert -sv
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/commit_ctrl.sv
// commit control for the two retirement ports
// decides acknowledges, store commit, CSR commit and fence activity

`timescale 1ns/1ps
`default_nettype none

module commit_ctrl (
    input  commit_pkg::sb_entry_t [1:0] instr_i,
    input  logic                        retire_ok_i,
    input  logic                        exc_valid_i,
    input  logic                        lsu_ready_i,
    input  logic                        fence_done_i,
    output logic [1:0]                  ack_o,
    output logic                        lsu_commit_o,
    output logic                        csr_commit_o,
    output logic                        fence_active_o
);

    logic is_store0;
    logic is_csr0;
    logic is_fence0;
    logic stall0;
    logic port1_fu_ok;

    // ------------------------------------------------------------
    // port 0
    // ------------------------------------------------------------

    assign is_store0 = instr_i[0].fu == commit_pkg::STORE;
    assign is_csr0   = instr_i[0].fu == commit_pkg::CSR;
    assign is_fence0 = instr_i[0].op == commit_pkg::FENCE;

    always_comb begin
        stall0 = 1'b0;
        // store buffer full, hold the store
        if (is_store0 && !lsu_ready_i) begin
            stall0 = 1'b1;
        end
        // csr access faulted, the trap is taken instead
        if (is_csr0 && exc_valid_i) begin
            stall0 = 1'b1;
        end
        // fence retires only on the cycle the sequencer finishes
        if (is_fence0 && !fence_done_i) begin
            stall0 = 1'b1;
        end
    end

    assign ack_o[0] = retire_ok_i && !stall0;

    // side effects follow the acknowledge
    assign lsu_commit_o   = ack_o[0] && is_store0;
    assign csr_commit_o   = ack_o[0] && is_csr0;
    assign fence_active_o = retire_ok_i && is_fence0;

    // ------------------------------------------------------------
    // port 1
    // ------------------------------------------------------------

    // only units without side effects at commit may pair up
    assign port1_fu_ok = instr_i[1].fu inside {commit_pkg::ALU, commit_pkg::LOAD,
                                               commit_pkg::CTRL_FLOW, commit_pkg::MULT,
                                               commit_pkg::FPU};

    // csr on port 0 may change state port 1 depends on
    assign ack_o[1] = ack_o[0] && !is_csr0 && instr_i[1].valid
                      && !instr_i[1].ex.valid && port1_fu_ok;

    // in-order retirement, port 1 never passes port 0
    always_comb begin
        assert (!ack_o[1] || ack_o[0])
            else $error("port 1 retired without port 0");
    end

endmodule

`default_nettype wire

//--- logic/commit_defines.svh
// commit stage widths
// shared by the package, the RTL and the testbench

`ifndef COMMIT_DEFINES_SVH
`define COMMIT_DEFINES_SVH

// data path width, reduced from 64
`define CM_XLEN     32

// architectural register address
`define CM_REG_AW   5

// scoreboard transaction id
`define CM_TRANS_W  3

// floating point exception flags (NV DZ OF UF NX)
`define CM_FFLAGS_W 5

// fence op forwarded to the L2
`define CM_FENCE_W  2

`endif

//--- logic/commit_pkg.sv
// commit stage types
// scoreboard entry, exception, register file and CSR request formats

`default_nettype none

`include "commit_defines.svh"

package commit_pkg;

    // ------------------------------------------------------------
    // decode enums
    // ------------------------------------------------------------

    // functional unit that produced the entry
    typedef enum logic [2:0] {
        NONE, ALU, LOAD, STORE, CTRL_FLOW, MULT, CSR, FPU
    } fu_t;

    // operation, ADD doubles as the CSR no-op
    typedef enum logic [3:0] {
        ADD, CSR_RW, CSR_RS, CSR_RC, FENCE, OTHER
    } op_t;

    // fence sequencer states
    typedef enum logic [1:0] {
        FS_IDLE, FS_WAIT_READY, FS_VALID, FS_WAIT_DONE
    } fence_state_t;

    // ------------------------------------------------------------
    // exception word
    // ------------------------------------------------------------

    // fpu entries reuse the cause word to carry their flags
    typedef struct packed {
        logic [`CM_XLEN-`CM_FFLAGS_W-1:0] pad;
        logic [`CM_FFLAGS_W-1:0]          fflags;
    } fflags_view_t;

    typedef union packed {
        logic [`CM_XLEN-1:0] code;
        fflags_view_t        flags;
    } cause_u;

    typedef struct packed {
        logic                valid;
        cause_u              cause;
        logic [`CM_XLEN-1:0] tval;
    } exception_t;

    // ------------------------------------------------------------
    // scoreboard and commit interfaces
    // ------------------------------------------------------------

    typedef struct packed {
        logic                       valid;
        fu_t                        fu;
        op_t                        op;
        logic [`CM_REG_AW-1:0]      rd;
        logic                       rd_is_fpr;
        logic [`CM_XLEN-1:0]        result;
        logic [`CM_TRANS_W-1:0]     trans_id;
        logic [`CM_FENCE_W-1:0]     fence_op;
        exception_t                 ex;
    } sb_entry_t;

    // one register file write port, gpr and fpr share address and data
    typedef struct packed {
        logic [`CM_REG_AW-1:0] waddr;
        logic [`CM_XLEN-1:0]   wdata;
        logic                  we_gpr;
        logic                  we_fpr;
    } rf_write_t;

    typedef struct packed {
        op_t                 op;
        logic [`CM_XLEN-1:0] wdata;
        logic                write_fflags;
        logic                commit;
    } csr_req_t;

endpackage

`default_nettype wire

//--- logic/commit_stage.sv
// dual port commit stage of the in-order core
// retires scoreboard entries into the register files, LSU, CSRs and L2

`timescale 1ns/1ps
`default_nettype none

`include "commit_defines.svh"

module commit_stage (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        halt_i,
    // scoreboard head
    input  commit_pkg::sb_entry_t [1:0] commit_instr_i,
    output logic [1:0]                  commit_ack_o,
    // register files
    output commit_pkg::rf_write_t [1:0] rf_write_o,
    // csr file
    output commit_pkg::csr_req_t        csr_req_o,
    input  logic [`CM_XLEN-1:0]         csr_rdata_i,
    input  commit_pkg::exception_t      csr_exception_i,
    // trap to the controller
    output commit_pkg::exception_t      exception_o,
    // load/store unit
    output logic                        commit_lsu_o,
    input  logic                        commit_lsu_ready_i,
    input  logic                        no_st_pending_i,
    // fence towards the cache and L2
    output logic                        fence_o,
    output logic                        fence_l2_valid_o,
    output logic [`CM_FENCE_W-1:0]      fence_l2_data_o,
    input  logic                        fence_l2_ready_i
);

    logic retire_ok;
    logic fence_done;
    logic fence_active;
    logic csr_commit;

    trap_select trap_select_inst (
        .entry0_i        (commit_instr_i[0]),
        .csr_exception_i (csr_exception_i),
        .halt_i          (halt_i),
        .exception_o     (exception_o),
        .retire_ok_o     (retire_ok)
    );

    commit_ctrl commit_ctrl_inst (
        .instr_i        (commit_instr_i),
        .retire_ok_i    (retire_ok),
        .exc_valid_i    (exception_o.valid),
        .lsu_ready_i    (commit_lsu_ready_i),
        .fence_done_i   (fence_done),
        .ack_o          (commit_ack_o),
        .lsu_commit_o   (commit_lsu_o),
        .csr_commit_o   (csr_commit),
        .fence_active_o (fence_active)
    );

    fence_seq fence_seq_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .active_i        (fence_active),
        .fence_op_i      (commit_instr_i[0].fence_op),
        .no_st_pending_i (no_st_pending_i),
        .l2_ready_i      (fence_l2_ready_i),
        .l2_valid_o      (fence_l2_valid_o),
        .l2_data_o       (fence_l2_data_o),
        .fence_done_o    (fence_done),
        .fence_o         (fence_o)
    );

    regfile_write regfile_write_inst (
        .instr_i      (commit_instr_i),
        .ack_i        (commit_ack_o),
        .csr_commit_i (csr_commit),
        .csr_rdata_i  (csr_rdata_i),
        .rf_write_o   (rf_write_o)
    );

    csr_update csr_update_inst (
        .instr_i   (commit_instr_i),
        .ack_i     (commit_ack_o),
        .csr_req_o (csr_req_o)
    );

endmodule

`default_nettype wire

//--- logic/csr_update.sv
// CSR update request
// CSR op and data from port 0, fflags accumulated over both ports

`timescale 1ns/1ps
`default_nettype none

`include "commit_defines.svh"

module csr_update (
    input  commit_pkg::sb_entry_t [1:0] instr_i,
    input  logic [1:0]                  ack_i,
    output commit_pkg::csr_req_t        csr_req_o
);

    logic                    csr0;
    logic [1:0]              fpu_ack;
    logic [`CM_FFLAGS_W-1:0] flags;

    assign csr0       = ack_i[0] && instr_i[0].fu == commit_pkg::CSR;
    assign fpu_ack[0] = ack_i[0] && instr_i[0].fu == commit_pkg::FPU;
    assign fpu_ack[1] = ack_i[1] && instr_i[1].fu == commit_pkg::FPU;

    // OR of the flags of every retiring fpu op
    assign flags = (fpu_ack[0] ? instr_i[0].ex.cause.flags.fflags : '0)
                 | (fpu_ack[1] ? instr_i[1].ex.cause.flags.fflags : '0);

    always_comb begin
        csr_req_o    = '0;
        csr_req_o.op = commit_pkg::ADD;
        if (csr0) begin
            csr_req_o.op     = instr_i[0].op;
            csr_req_o.wdata  = instr_i[0].result;
            csr_req_o.commit = 1'b1;
        end
        // csr on port 0 blocks port 1, so the two cases never overlap
        if (|fpu_ack) begin
            csr_req_o.write_fflags = 1'b1;
            csr_req_o.wdata = {{(`CM_XLEN-`CM_FFLAGS_W){1'b0}}, flags};
        end
    end

endmodule

`default_nettype wire

//--- logic/fence_seq.sv
// FENCE sequencer
// drains stores, then runs the level based exchange with the L2

`timescale 1ns/1ps
`default_nettype none

`include "commit_defines.svh"

module fence_seq (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   active_i,
    input  logic [`CM_FENCE_W-1:0] fence_op_i,
    input  logic                   no_st_pending_i,
    input  logic                   l2_ready_i,
    output logic                   l2_valid_o,
    output logic [`CM_FENCE_W-1:0] l2_data_o,
    output logic                   fence_done_o,
    output logic                   fence_o
);

    commit_pkg::fence_state_t state_d;
    commit_pkg::fence_state_t state_q;

    always_comb begin
        state_d      = state_q;
        l2_valid_o   = 1'b0;
        l2_data_o    = '0;
        fence_done_o = 1'b0;
        fence_o      = 1'b0;
        // sequencer frozen while no fence sits at the head
        if (active_i) begin
            case (state_q)
                commit_pkg::FS_IDLE: begin
                    // wait for the store buffer to drain
                    if (no_st_pending_i) begin
                        state_d = commit_pkg::FS_WAIT_READY;
                    end
                end
                commit_pkg::FS_WAIT_READY: begin
                    if (fence_op_i == '0) begin
                        // nothing for the L2, just wait for ready
                        state_d = commit_pkg::FS_WAIT_DONE;
                    end else if (l2_ready_i) begin
                        l2_valid_o = 1'b1;
                        l2_data_o  = fence_op_i;
                        state_d    = commit_pkg::FS_VALID;
                    end
                end
                commit_pkg::FS_VALID: begin
                    // L2 drops ready while it works on the fence
                    if (!l2_ready_i) begin
                        state_d = commit_pkg::FS_WAIT_DONE;
                    end
                end
                commit_pkg::FS_WAIT_DONE: begin
                    // ready back high, fence complete
                    if (l2_ready_i) begin
                        fence_done_o = 1'b1;
                        fence_o      = no_st_pending_i;
                        state_d      = commit_pkg::FS_IDLE;
                    end
                end
                default: state_d = commit_pkg::FS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= commit_pkg::FS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // one valid pulse per fence
    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        l2_valid_o |=> !l2_valid_o);

    // completion only while commit still presents the fence
    a_done_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fence_done_o |-> active_i);

endmodule

`default_nettype wire

//--- logic/regfile_write.sv
// register file write ports
// port 0 returns CSR read data when a CSR instruction commits

`timescale 1ns/1ps
`default_nettype none

`include "commit_defines.svh"

module regfile_write (
    input  commit_pkg::sb_entry_t [1:0] instr_i,
    input  logic [1:0]                  ack_i,
    input  logic                        csr_commit_i,
    input  logic [`CM_XLEN-1:0]         csr_rdata_i,
    output commit_pkg::rf_write_t [1:0] rf_write_o
);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rf_write_o[i].waddr  = instr_i[i].rd;
            rf_write_o[i].wdata  = instr_i[i].result;
            // enable tracks the ack exactly, target file picked by rd_is_fpr
            rf_write_o[i].we_fpr = ack_i[i] && instr_i[i].rd_is_fpr;
            rf_write_o[i].we_gpr = ack_i[i] && !instr_i[i].rd_is_fpr;
        end
        // csr instructions write back the old CSR value
        if (csr_commit_i) begin
            rf_write_o[0].wdata = csr_rdata_i;
        end
    end

endmodule

`default_nettype wire

//--- logic/trap_select.sv
// trap selection for the head of the queue
// entry exception wins over the CSR exception, halt masks both

`timescale 1ns/1ps
`default_nettype none

module trap_select (
    input  commit_pkg::sb_entry_t  entry0_i,
    input  commit_pkg::exception_t csr_exception_i,
    input  logic                   halt_i,
    output commit_pkg::exception_t exception_o,
    output logic                   retire_ok_o
);

    always_comb begin
        exception_o = '0;
        if (entry0_i.valid) begin
            // csr fault reported with the entry's tval
            if (csr_exception_i.valid) begin
                exception_o      = csr_exception_i;
                exception_o.tval = entry0_i.ex.tval;
            end
            // earlier pipeline faults take precedence
            if (entry0_i.ex.valid) begin
                exception_o = entry0_i.ex;
            end
        end
        // no trap while the core is halted
        if (halt_i) begin
            exception_o.valid = 1'b0;
        end
    end

    assign retire_ok_o = entry0_i.valid && !entry0_i.ex.valid && !halt_i;

    always_comb begin
        assert (!(halt_i && exception_o.valid))
            else $error("trap raised during halt");
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+logic
logic/commit_pkg.sv
logic/commit_ctrl.sv
logic/trap_select.sv
logic/fence_seq.sv
logic/regfile_write.sv
logic/csr_update.sv
logic/commit_stage.sv
verification/commit_tb.sv

//--- verification/commit_tb.sv
// testbench for the dual port commit stage
// random scoreboard traffic checked against a cycle model and an L2 fence responder

`timescale 1ns/1ps
`default_nettype none

`include "commit_defines.svh"

module commit_tb;

    localparam int NUM_PAIRS  = 400;
    localparam int HOLD_LIMIT = 200;

    // fence sequencer states of the model
    localparam int S_IDLE  = 0;
    localparam int S_READY = 1;
    localparam int S_SENT  = 2;
    localparam int S_DONE  = 3;

    logic                        clk_i;
    logic                        rst_ni;
    logic                        halt;
    commit_pkg::sb_entry_t [1:0] commit_instr;
    logic [1:0]                  commit_ack;
    commit_pkg::rf_write_t [1:0] rf_write;
    commit_pkg::csr_req_t        csr_req;
    logic [`CM_XLEN-1:0]         csr_rdata;
    commit_pkg::exception_t      csr_exception;
    commit_pkg::exception_t      exception;
    logic                        commit_lsu;
    logic                        lsu_ready;
    logic                        no_st_pending;
    logic                        fence;
    logic                        l2_valid;
    logic [`CM_FENCE_W-1:0]      l2_data;
    logic                        l2_ready = 1'b1;

    // model state and flags passed from the checker to the drivers
    int          m_state = S_IDLE;
    int          m_next = S_IDLE;
    logic        advance = 1'b1;
    logic        l2_valid_seen = 1'b0;
    int          pulses = 0;
    int unsigned l2_phase = 0;
    int unsigned l2_count = 0;
    int          n_dual = 0;
    int          n_store = 0;
    int          n_csr = 0;
    int          n_fflags = 0;
    int          n_trap = 0;
    int          n_fence_l2 = 0;
    int          n_fence_zero = 0;

    commit_stage commit_stage_inst (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .halt_i             (halt),
        .commit_instr_i     (commit_instr),
        .commit_ack_o       (commit_ack),
        .rf_write_o         (rf_write),
        .csr_req_o          (csr_req),
        .csr_rdata_i        (csr_rdata),
        .csr_exception_i    (csr_exception),
        .exception_o        (exception),
        .commit_lsu_o       (commit_lsu),
        .commit_lsu_ready_i (lsu_ready),
        .no_st_pending_i    (no_st_pending),
        .fence_o            (fence),
        .fence_l2_valid_o   (l2_valid),
        .fence_l2_data_o    (l2_data),
        .fence_l2_ready_i   (l2_ready)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // one scoreboard entry from a mix of all units plus fences
    function automatic commit_pkg::sb_entry_t random_entry();
        commit_pkg::sb_entry_t e;
        int unsigned           kind;
        e = '0;
        kind = $urandom % 10;
        e.valid = ($urandom % 8) != 0;
        e.op = commit_pkg::OTHER;
        e.rd = 5'($urandom);
        e.rd_is_fpr = 1'($urandom);
        e.result = $urandom;
        e.trans_id = 3'($urandom);
        e.ex.tval = $urandom;
        case (kind)
            0: e.fu = commit_pkg::ALU;
            1: e.fu = commit_pkg::LOAD;
            2: e.fu = commit_pkg::STORE;
            3: e.fu = commit_pkg::CTRL_FLOW;
            4: e.fu = commit_pkg::MULT;
            5: begin
                e.fu = commit_pkg::CSR;
                case ($urandom % 4)
                    0: e.op = commit_pkg::ADD;
                    1: e.op = commit_pkg::CSR_RW;
                    2: e.op = commit_pkg::CSR_RS;
                    default: e.op = commit_pkg::CSR_RC;
                endcase
            end
            // fpu flags live in the cause word
            6, 7: begin
                e.fu = commit_pkg::FPU;
                e.ex.cause.flags.fflags = 5'($urandom);
            end
            8: begin
                e.fu = commit_pkg::NONE;
                e.op = commit_pkg::FENCE;
                e.fence_op = 2'($urandom);
            end
            default: e.fu = commit_pkg::NONE;
        endcase
        if ($urandom % 10 == 0) begin
            e.ex.valid = 1'b1;
            e.ex.cause.code = $urandom;
        end
        return e;
    endfunction

    // per cycle levels from the CSR file, LSU and controller
    task automatic drive_levels();
        commit_pkg::exception_t ce;
        ce = '0;
        ce.valid = ($urandom % 8) == 0;
        ce.cause.code = $urandom;
        ce.tval = $urandom;
        csr_exception <= ce;
        // a halt in the valid-sent state could hide a short ready drop from the sequencer
        halt <= (m_next != S_SENT) && (($urandom % 16) == 0);
        lsu_ready <= ($urandom % 4) != 0;
        no_st_pending <= ($urandom % 2) == 0;
        csr_rdata <= $urandom;
    endtask

    // ------------------------------------------------------------
    // reference model and checks evaluated mid cycle
    // ------------------------------------------------------------

    task automatic check_cycle();
        commit_pkg::sb_entry_t   e0;
        commit_pkg::sb_entry_t   e1;
        commit_pkg::exception_t  exp_exc;
        logic                    retire_ok;
        logic                    is_fence;
        logic                    fence_done;
        logic                    exp_l2_valid;
        logic                    exp_fence;
        logic                    stall;
        logic [1:0]              exp_ack;
        logic                    csr0;
        logic                    fpu_any;
        logic [`CM_FFLAGS_W-1:0] flags;
        e0 = commit_instr[0];
        e1 = commit_instr[1];
        // entry fault first and then the CSR fault with the entry tval
        exp_exc = '0;
        if (!halt && e0.valid && e0.ex.valid) begin
            exp_exc = e0.ex;
        end else if (!halt && e0.valid && csr_exception.valid) begin
            exp_exc.valid = 1'b1;
            exp_exc.cause = csr_exception.cause;
            exp_exc.tval = e0.ex.tval;
        end
        retire_ok = e0.valid && !e0.ex.valid && !halt;
        // fence sequencer frozen unless a retirable fence is at the head
        is_fence = e0.op == commit_pkg::FENCE;
        fence_done = 1'b0;
        exp_l2_valid = 1'b0;
        exp_fence = 1'b0;
        m_next = m_state;
        if (retire_ok && is_fence) begin
            case (m_state)
                S_IDLE: if (no_st_pending) m_next = S_READY;
                S_READY: begin
                    if (e0.fence_op == '0) begin
                        m_next = S_DONE;
                    end else if (l2_ready) begin
                        exp_l2_valid = 1'b1;
                        m_next = S_SENT;
                    end
                end
                S_SENT: if (!l2_ready) m_next = S_DONE;
                default: begin
                    if (l2_ready) begin
                        fence_done = 1'b1;
                        exp_fence = no_st_pending;
                        m_next = S_IDLE;
                    end
                end
            endcase
        end
        // back pressure on port 0 and the pairing rule of port 1
        stall = (e0.fu == commit_pkg::STORE && !lsu_ready)
              || (e0.fu == commit_pkg::CSR && exp_exc.valid)
              || (is_fence && !fence_done);
        exp_ack[0] = retire_ok && !stall;
        exp_ack[1] = exp_ack[0] && e0.fu != commit_pkg::CSR && e1.valid && !e1.ex.valid
                     && e1.fu inside {commit_pkg::ALU, commit_pkg::LOAD, commit_pkg::CTRL_FLOW,
                                      commit_pkg::MULT, commit_pkg::FPU};
        csr0 = exp_ack[0] && e0.fu == commit_pkg::CSR;
        fpu_any = (exp_ack[0] && e0.fu == commit_pkg::FPU)
                  || (exp_ack[1] && e1.fu == commit_pkg::FPU);
        flags = '0;
        if (exp_ack[0] && e0.fu == commit_pkg::FPU) flags = flags | e0.ex.cause.flags.fflags;
        if (exp_ack[1] && e1.fu == commit_pkg::FPU) flags = flags | e1.ex.cause.flags.fflags;

        compare("commit_ack", 64'(commit_ack), 64'(exp_ack));
        compare("commit_lsu", 64'(commit_lsu), 64'(exp_ack[0] && e0.fu == commit_pkg::STORE));
        compare("exception valid", 64'(exception.valid), 64'(exp_exc.valid));
        if (exp_exc.valid) begin
            compare("exception cause", 64'(exception.cause.code), 64'(exp_exc.cause.code));
            compare("exception tval", 64'(exception.tval), 64'(exp_exc.tval));
        end
        compare("fence_l2_valid", 64'(l2_valid), 64'(exp_l2_valid));
        compare("fence", 64'(fence), 64'(exp_fence));
        if (exp_l2_valid) compare("fence_l2_data", 64'(l2_data), 64'(e0.fence_op));
        for (int i = 0; i < 2; i++) begin
            compare("we_gpr", 64'(rf_write[i].we_gpr),
                    64'(exp_ack[i] && !commit_instr[i].rd_is_fpr));
            compare("we_fpr", 64'(rf_write[i].we_fpr),
                    64'(exp_ack[i] && commit_instr[i].rd_is_fpr));
            if (exp_ack[i]) begin
                compare("rf waddr", 64'(rf_write[i].waddr), 64'(commit_instr[i].rd));
                compare("rf wdata", 64'(rf_write[i].wdata),
                        64'((i == 0 && csr0) ? csr_rdata : commit_instr[i].result));
            end
        end
        compare("csr op", 64'(csr_req.op), 64'(csr0 ? e0.op : commit_pkg::ADD));
        compare("csr commit", 64'(csr_req.commit), 64'(csr0));
        compare("csr write_fflags", 64'(csr_req.write_fflags), 64'(fpu_any));
        if (fpu_any) begin
            compare("csr wdata fflags", 64'(csr_req.wdata), 64'(flags));
        end else if (csr0) begin
            compare("csr wdata", 64'(csr_req.wdata), 64'(e0.result));
        end
        // exactly one L2 pulse for a nonzero fence op and none for a zero op
        if (l2_valid) pulses++;
        if (exp_ack[0] && is_fence) begin
            compare("fence l2 pulses", 64'(pulses), 64'(e0.fence_op != '0));
            if (e0.fence_op != '0) n_fence_l2++;
            else n_fence_zero++;
        end
        if (exp_ack[0]) pulses = 0;
        if (exp_ack == 2'b11) n_dual++;
        if (exp_ack[0] && e0.fu == commit_pkg::STORE) n_store++;
        if (csr0) n_csr++;
        if (fpu_any) n_fflags++;
        if (exp_exc.valid) n_trap++;
        // a faulting or empty head is flushed upstream
        advance = exp_ack[0] || !(e0.valid && !e0.ex.valid);
    endtask

    always @(negedge clk_i) begin
        if (rst_ni) begin
            check_cycle();
        end
        l2_valid_seen = l2_valid;
    end

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            m_state <= S_IDLE;
        end else begin
            m_state <= m_next;
        end
    end

    // L2 responder drops ready 1 or 2 cycles after it sees valid and raises it after a delay
    always @(posedge clk_i) begin
        if (rst_ni) begin
            case (l2_phase)
                0: begin
                    if (l2_valid_seen) begin
                        l2_count <= $urandom % 2;
                        l2_phase <= 1;
                    end
                end
                1: begin
                    if (l2_count == 0) begin
                        l2_ready <= 1'b0;
                        l2_count <= 1 + $urandom % 6;
                        l2_phase <= 2;
                    end else begin
                        l2_count <= l2_count - 1;
                    end
                end
                default: begin
                    if (l2_count <= 1) begin
                        l2_ready <= 1'b1;
                        l2_phase <= 0;
                    end else begin
                        l2_count <= l2_count - 1;
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    initial begin
        int unsigned hold;
        int          pairs;
        void'($urandom(18));
        rst_ni = 1'b0;
        halt = 1'b0;
        commit_instr = '0;
        csr_rdata = '0;
        csr_exception = '0;
        lsu_ready = 1'b0;
        no_st_pending = 1'b0;
        hold = 0;
        pairs = 0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        // a pair stays at the head until port 0 retires it
        while (pairs < NUM_PAIRS) begin
            @(posedge clk_i);
            if (advance) begin
                commit_instr <= {random_entry(), random_entry()};
                pairs++;
                hold = 0;
            end else begin
                hold++;
                if (hold > HOLD_LIMIT) begin
                    $display("timeout: head entry not retired within %0d cycles", HOLD_LIMIT);
                    stop_with_failure();
                end
            end
            drive_levels();
        end
        @(posedge clk_i);
        $display("dual %0d store %0d csr %0d fflags %0d trap %0d fence l2 %0d fence zero %0d",
                 n_dual, n_store, n_csr, n_fflags, n_trap, n_fence_l2, n_fence_zero);
        if (n_fence_l2 > 0 && n_fence_zero > 0 && n_csr > 0 && n_fflags > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("random stimulus never retired a fence, CSR or FPU instruction");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire
